//--- src/cart_pkg.sv
package cart_pkg;

    // ==============================
    // widths with a meaning
    // ==============================
    typedef logic [15:0] req_addr_t;   // cpu address, ppu address in low 14 bits
    typedef logic [7:0]  data_t;
    typedef logic [11:0] cfg_word_t;
    typedef logic [4:0]  mapper_id_t;
    typedef logic [4:0]  prg_bits_t;   // log2 of prg size, 0 = no masking
    typedef logic [2:0]  op_t;
    typedef logic [1:0]  target_t;

    // config word layout, from bit 0 up
    localparam int CFG_MAPPER_LSB  = 0;
    localparam int CFG_PRG_LSB     = 5;
    localparam int CFG_MIRROR_BIT  = 10;  // 0 horizontal, 1 vertical
    localparam int CFG_CHR_RAM_BIT = 11;

    // ==============================
    // operation codes
    // ==============================
    localparam op_t OP_PRG_READ    = 3'd0;
    localparam op_t OP_CHR_READ    = 3'd1;
    localparam op_t OP_CHR_WRITE   = 3'd2;
    localparam op_t OP_CIRAM_READ  = 3'd3;
    localparam op_t OP_CIRAM_WRITE = 3'd4;
    localparam op_t OP_BANK_WRITE  = 3'd5;  // cpu write at 0x8000 and up
    localparam op_t OP_CFG         = 3'd6;

    // ==============================
    // memory targets
    // ==============================
    localparam target_t TARGET_PRG   = 2'd0;
    localparam target_t TARGET_CHR   = 2'd1;
    localparam target_t TARGET_CIRAM = 2'd2;

    // mapper numbers, unknown ids act like nrom
    localparam mapper_id_t MAPPER_NROM  = 5'd0;
    localparam mapper_id_t MAPPER_UXROM = 5'd2;
    localparam mapper_id_t MAPPER_CNROM = 5'd3;

endpackage

//--- src/access_if.sv
`timescale 1ns/100ps

interface access_if #(
    parameter int ADDR_BITS = 23
);
    logic valid;
    logic ready;
    cart_pkg::op_t op;
    logic [ADDR_BITS-1:0] addr;   // request address, banked address or config word
    cart_pkg::data_t wdata;

    modport src (
        output valid,
        output op,
        output addr,
        output wdata,
        input  ready
    );

    modport dst (
        input  valid,
        input  op,
        input  addr,
        input  wdata,
        output ready
    );

endinterface

//--- src/access_decode.sv
`timescale 1ns/100ps

module access_decode (
    input  logic                clk,
    input  logic                cpu_reset,

    input  logic                cfg_valid,
    output logic                cfg_ready,
    input  cart_pkg::cfg_word_t cfg_data,

    input  logic                req_valid,
    output logic                req_ready,
    input  logic                req_ppu,
    input  logic                req_write,
    input  cart_pkg::req_addr_t req_addr,
    input  cart_pkg::data_t     req_wdata,

    access_if.src               dn
);
    logic take;
    logic chr_ram;                  // chr writes allowed
    logic keep;                     // request produces an item
    cart_pkg::op_t req_op;
    cart_pkg::req_addr_t item_addr;

    assign take = !dn.valid || dn.ready;
    assign cfg_ready = take;
    assign req_ready = take && !cfg_valid;  // config wins

    // ==============================
    // classify the request
    // ==============================
    always_comb begin
        req_op = cart_pkg::OP_PRG_READ;
        keep = 1'b1;
        if (!req_ppu) begin
            keep = req_addr[15];    // nothing mapped below 0x8000
            if (req_write)
                req_op = cart_pkg::OP_BANK_WRITE;
        end else if (req_addr[13]) begin
            req_op = req_write ? cart_pkg::OP_CIRAM_WRITE : cart_pkg::OP_CIRAM_READ;
        end else if (req_write) begin
            req_op = cart_pkg::OP_CHR_WRITE;
            keep = chr_ram;         // chr rom ignores writes
        end else begin
            req_op = cart_pkg::OP_CHR_READ;
        end
    end

    always_comb begin
        dn.addr = '0;
        dn.addr[15:0] = item_addr;
    end

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            dn.valid <= 1'b0;
            chr_ram <= 1'b0;
        end else if (take) begin
            dn.valid <= cfg_valid || (req_valid && keep);
            if (cfg_valid)
                chr_ram <= cfg_data[cart_pkg::CFG_CHR_RAM_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (cfg_valid) begin
                dn.op <= cart_pkg::OP_CFG;
                item_addr <= {4'd0, cfg_data};  // word rides in the address field
            end else begin
                dn.op <= req_op;
                item_addr <= req_addr;
            end
            dn.wdata <= req_wdata;
        end
    end

endmodule

//--- src/bank_execute.sv
`timescale 1ns/100ps

module bank_execute #(
    parameter int ADDR_BITS = 23
) (
    input  logic  clk,
    input  logic  cpu_reset,
    access_if.dst up,
    access_if.src dn
);
    logic take;
    cart_pkg::cfg_word_t cfg;
    cart_pkg::mapper_id_t mapper_id;
    logic mirroring;                // 1 = vertical
    logic [3:0] prg_bank;           // uxrom switchable 16k bank
    logic [1:0] chr_bank;           // cnrom 8k bank
    logic ciram_a10;
    logic [ADDR_BITS-1:0] banked_addr;

    assign take = !dn.valid || dn.ready;
    assign up.ready = take;
    assign cfg = up.addr[11:0];
    assign ciram_a10 = mirroring ? up.addr[10] : up.addr[11];

    // ==============================
    // address banking
    // ==============================
    always_comb begin
        banked_addr = '0;
        case (up.op)
            cart_pkg::OP_PRG_READ: begin
                if (mapper_id == cart_pkg::MAPPER_UXROM) begin
                    if (up.addr[14])
                        banked_addr = '1;   // masking later picks the last bank
                    else
                        banked_addr[17:14] = prg_bank;
                    banked_addr[13:0] = up.addr[13:0];
                end else begin
                    banked_addr[14:0] = up.addr[14:0];
                end
            end
            cart_pkg::OP_CHR_READ, cart_pkg::OP_CHR_WRITE: begin
                if (mapper_id == cart_pkg::MAPPER_CNROM)
                    banked_addr[14:13] = chr_bank;
                banked_addr[12:0] = up.addr[12:0];
            end
            cart_pkg::OP_CIRAM_READ, cart_pkg::OP_CIRAM_WRITE: begin
                banked_addr[10] = ciram_a10;
                banked_addr[9:0] = up.addr[9:0];
            end
            default: begin
                banked_addr = up.addr;      // config word goes on to result
            end
        endcase
    end

    // ==============================
    // mapper registers
    // ==============================
    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            dn.valid <= 1'b0;
            mapper_id <= '0;
            mirroring <= 1'b0;
            prg_bank <= '0;
            chr_bank <= '0;
        end else if (take) begin
            dn.valid <= up.valid && (up.op != cart_pkg::OP_BANK_WRITE);
            if (up.valid && up.op == cart_pkg::OP_CFG) begin
                mapper_id <= cfg[cart_pkg::CFG_MAPPER_LSB +: 5];
                mirroring <= cfg[cart_pkg::CFG_MIRROR_BIT];
                prg_bank <= '0;
                chr_bank <= '0;
            end
            if (up.valid && up.op == cart_pkg::OP_BANK_WRITE) begin
                case (mapper_id)
                    cart_pkg::MAPPER_UXROM: prg_bank <= up.wdata[3:0];
                    cart_pkg::MAPPER_CNROM: chr_bank <= up.wdata[1:0];
                    default: ;              // nrom has no registers
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dn.op <= up.op;
            dn.addr <= banked_addr;
            dn.wdata <= up.wdata;
        end
    end

endmodule

//--- src/access_result.sv
`timescale 1ns/100ps

module access_result #(
    parameter int ADDR_BITS = 23
) (
    input  logic                  clk,
    input  logic                  cpu_reset,
    access_if.dst                 up,

    output logic                  mem_valid,
    input  logic                  mem_ready,
    output cart_pkg::target_t     mem_target,
    output logic                  mem_write,
    output logic [ADDR_BITS-1:0]  mem_addr,
    output cart_pkg::data_t       mem_wdata
);
    logic take;
    cart_pkg::cfg_word_t cfg;
    cart_pkg::prg_bits_t prg_bits;
    logic [ADDR_BITS-1:0] size_bit;     // prg size, also the chr base
    logic [ADDR_BITS-1:0] flat_addr;
    cart_pkg::target_t target;
    logic is_write;

    assign take = !mem_valid || mem_ready;
    assign up.ready = take;
    assign cfg = up.addr[11:0];
    assign size_bit = ADDR_BITS'(1) << prg_bits;

    // ==============================
    // place into flat memory
    // ==============================
    always_comb begin
        flat_addr = up.addr;
        target = cart_pkg::TARGET_CIRAM;
        is_write = 1'b0;
        case (up.op)
            cart_pkg::OP_PRG_READ: begin
                target = cart_pkg::TARGET_PRG;
                if (prg_bits != '0)
                    flat_addr = up.addr & (size_bit - 1'b1);
            end
            cart_pkg::OP_CHR_READ, cart_pkg::OP_CHR_WRITE: begin
                target = cart_pkg::TARGET_CHR;
                is_write = (up.op == cart_pkg::OP_CHR_WRITE);
                if (prg_bits != '0)
                    flat_addr = up.addr | size_bit;  // chr right after prg
            end
            default: begin
                is_write = (up.op == cart_pkg::OP_CIRAM_WRITE);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            mem_valid <= 1'b0;
            prg_bits <= '0;
        end else if (take) begin
            mem_valid <= up.valid && (up.op != cart_pkg::OP_CFG);
            if (up.valid && up.op == cart_pkg::OP_CFG)
                prg_bits <= cfg[cart_pkg::CFG_PRG_LSB +: 5];
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mem_target <= target;
            mem_write <= is_write;
            mem_addr <= flat_addr;
            mem_wdata <= up.wdata;
        end
    end

endmodule

//--- src/cart_mapper_top.sv
`timescale 1ns/100ps

module cart_mapper_top #(
    parameter int ADDR_BITS = 23    // flat memory address width
) (
    input  logic                  clk,
    input  logic                  cpu_reset,

    // ==============================
    // host configuration
    // ==============================
    input  logic                  cfg_valid,
    output logic                  cfg_ready,
    input  cart_pkg::cfg_word_t   cfg_data,

    // cpu and ppu requests
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_ppu,
    input  logic                  req_write,
    input  cart_pkg::req_addr_t   req_addr,
    input  cart_pkg::data_t       req_wdata,

    // ==============================
    // memory port
    // ==============================
    output logic                  mem_valid,
    input  logic                  mem_ready,
    output cart_pkg::target_t     mem_target,
    output logic                  mem_write,
    output logic [ADDR_BITS-1:0]  mem_addr,
    output cart_pkg::data_t       mem_wdata
);
    access_if #(.ADDR_BITS(ADDR_BITS)) dec_to_exe ();
    access_if #(.ADDR_BITS(ADDR_BITS)) exe_to_res ();

    access_decode u_decode (
        .clk       (clk),
        .cpu_reset (cpu_reset),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .cfg_data  (cfg_data),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_ppu   (req_ppu),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .dn        (dec_to_exe.src)
    );

    bank_execute #(.ADDR_BITS(ADDR_BITS)) u_execute (
        .clk       (clk),
        .cpu_reset (cpu_reset),
        .up        (dec_to_exe.dst),
        .dn        (exe_to_res.src)
    );

    access_result #(.ADDR_BITS(ADDR_BITS)) u_result (
        .clk        (clk),
        .cpu_reset  (cpu_reset),
        .up         (exe_to_res.dst),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_target (mem_target),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

endmodule

//--- verif/cart_mapper_tb.sv
`timescale 1ns/100ps

module cart_mapper_tb;

    localparam int ADDR_BITS = 23;
    localparam int CLK_PERIOD = 4;
    localparam int N_LATENCY = 16;
    localparam int N_RANDOM = 200;
    localparam int TOTAL_REQS = 11 + 7 + 6 + N_LATENCY + N_RANDOM;  // nrom, uxrom, cnrom, ...

    typedef struct packed {
        cart_pkg::target_t target;
        logic [ADDR_BITS-1:0] addr;
        logic write;
        cart_pkg::data_t wdata;
        logic [31:0] cycle;         // acceptance cycle
    } item_t;

    logic clk;
    logic cpu_reset;
    logic cfg_valid;
    logic cfg_ready;
    cart_pkg::cfg_word_t cfg_data;
    logic req_valid;
    logic req_ready;
    logic req_ppu;
    logic req_write;
    cart_pkg::req_addr_t req_addr;
    cart_pkg::data_t req_wdata;
    logic mem_valid;
    logic mem_ready;
    cart_pkg::target_t mem_target;
    logic mem_write;
    logic [ADDR_BITS-1:0] mem_addr;
    cart_pkg::data_t mem_wdata;

    item_t exp_q[$];
    string test_name = "reset";
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int n_checks = 0;
    logic [31:0] cycle = 0;
    logic rand_ready = 1'b0;        // random back-pressure on the memory port
    logic check_latency = 1'b0;

    // reference model state
    cart_pkg::mapper_id_t m_mapper;
    cart_pkg::prg_bits_t m_prg_bits;
    logic m_mirror;
    logic m_chr_ram;
    logic [3:0] m_prg_bank;
    logic [1:0] m_chr_bank;

    cart_mapper_top #(.ADDR_BITS(ADDR_BITS)) uut (
        .clk        (clk),
        .cpu_reset  (cpu_reset),
        .cfg_valid  (cfg_valid),
        .cfg_ready  (cfg_ready),
        .cfg_data   (cfg_data),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_ppu    (req_ppu),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_target (mem_target),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        mem_ready <= rand_ready ? 1'($urandom) : 1'b1;

    // ==============================
    // reference model
    // ==============================
    function automatic cart_pkg::cfg_word_t make_cfg(input logic chr_ram, input logic mirror,
            input cart_pkg::prg_bits_t prg_bits, input cart_pkg::mapper_id_t mapper);
        return {chr_ram, mirror, prg_bits, mapper};
    endfunction

    task automatic model_config(input cart_pkg::cfg_word_t word);
        m_mapper = word[4:0];
        m_prg_bits = word[9:5];
        m_mirror = word[10];
        m_chr_ram = word[11];
        m_prg_bank = '0;
        m_chr_bank = '0;
    endtask

    task automatic model_request(input logic ppu, input logic write,
            input cart_pkg::req_addr_t addr, input cart_pkg::data_t wdata);
        item_t e;
        logic [31:0] a;
        logic [31:0] size;
        size = 32'd1 << m_prg_bits;
        e.write = write;
        e.wdata = wdata;
        e.cycle = cycle;
        if (!ppu) begin
            if (!addr[15])
                return;             // open bus below 0x8000
            if (write) begin
                if (m_mapper == cart_pkg::MAPPER_UXROM)
                    m_prg_bank = wdata[3:0];
                else if (m_mapper == cart_pkg::MAPPER_CNROM)
                    m_chr_bank = wdata[1:0];
                return;
            end
            e.target = cart_pkg::TARGET_PRG;
            if (m_mapper == cart_pkg::MAPPER_UXROM)
                a = addr[14] ? {18'h3ffff, addr[13:0]} : {14'd0, m_prg_bank, addr[13:0]};
            else
                a = {17'd0, addr[14:0]};
            if (m_prg_bits != '0)
                a = a % size;       // wrap inside the prg size
        end else if (addr[13]) begin
            e.target = cart_pkg::TARGET_CIRAM;
            a = {21'd0, (m_mirror ? addr[10] : addr[11]), addr[9:0]};
        end else begin
            if (write && !m_chr_ram)
                return;
            e.target = cart_pkg::TARGET_CHR;
            if (m_mapper == cart_pkg::MAPPER_CNROM)
                a = {17'd0, m_chr_bank, addr[12:0]};
            else
                a = {19'd0, addr[12:0]};
            if (m_prg_bits != '0)
                a = a + size;       // chr sits after prg
        end
        e.addr = a[ADDR_BITS-1:0];
        exp_q.push_back(e);
    endtask

    // ==============================
    // scoreboard
    // ==============================
    always @(posedge clk) begin : monitor
        item_t e;
        cycle = cycle + 1;
        if (cpu_reset) begin
            if (cycle >= 2) begin
                assert (!mem_valid && cfg_ready && req_ready) else begin
                    $display("%s: mem_valid high or a ready low while reset is held", test_name);
                    errors++;
                end
            end
            exp_q.delete();
            model_config('0);
        end else begin
            if (mem_valid && mem_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("%s: memory transfer to %h while nothing was expected",
                             test_name, mem_addr);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    n_checks++;
                    assert (mem_target == e.target && mem_addr == e.addr
                             && mem_write == e.write) else begin
                        $display("mismatch %s: expected tgt/addr/wr %0d/%h/%b, actual %0d/%h/%b",
                                 test_name, e.target, e.addr, e.write,
                                 mem_target, mem_addr, mem_write);
                        errors++;
                    end
                    if (e.write) begin
                        assert (mem_wdata == e.wdata) else begin
                            $display("mismatch %s: expected wdata %h, actual wdata %h",
                                     test_name, e.wdata, mem_wdata);
                            errors++;
                        end
                    end
                    if (check_latency) begin
                        assert (cycle == e.cycle + 32'd3) else begin
                            $display("mismatch %s latency: expected 3 cycles, actual %0d",
                                     test_name, cycle - e.cycle);
                            errors++;
                        end
                    end
                end
            end
            if (cfg_valid && cfg_ready)
                model_config(cfg_data);
            if (req_valid && req_ready)
                model_request(req_ppu, req_write, req_addr, req_wdata);
        end
    end

    // ==============================
    // stimulus
    // ==============================
    task automatic send_cfg(input cart_pkg::cfg_word_t word);
        cfg_valid <= 1'b1;
        cfg_data <= word;
        do @(posedge clk); while (!cfg_ready);
        cfg_valid <= 1'b0;
    endtask

    task automatic send_req(input logic ppu, input logic write,
            input cart_pkg::req_addr_t addr, input cart_pkg::data_t wdata);
        req_valid <= 1'b1;
        req_ppu <= ppu;
        req_write <= write;
        req_addr <= addr;
        req_wdata <= wdata;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
    endtask

    task automatic drain();
        rand_ready <= 1'b0;
        do @(negedge clk); while (exp_q.size() != 0);
        repeat (6) @(posedge clk);  // catch anything extra
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %s finished with %0d errors", test_name, errors - test_errors);
    endtask

    task automatic reset_test();
        start_test("reset");
        repeat (10) @(posedge clk);
        cpu_reset <= 1'b0;
        @(posedge clk);
        assert (!mem_valid && cfg_ready && req_ready) else begin
            $display("reset: mem_valid high or a ready low after reset");
            errors++;
        end
        end_test();
    endtask

    task automatic nrom_test();
        start_test("nrom");
        send_cfg(make_cfg(1'b0, 1'b0, 5'd15, cart_pkg::MAPPER_NROM));
        send_req(1'b0, 1'b0, 16'h8000, 8'h00);
        send_req(1'b0, 1'b0, 16'hc123, 8'h00);
        send_req(1'b0, 1'b0, 16'hffff, 8'h00);
        send_req(1'b0, 1'b0, 16'h1234, 8'h00);  // unmapped
        send_req(1'b0, 1'b1, 16'h6000, 8'h11);
        send_req(1'b1, 1'b0, 16'h0000, 8'h00);
        send_req(1'b1, 1'b0, 16'h1abc, 8'h00);
        send_req(1'b1, 1'b0, 16'h2400, 8'h00);
        send_req(1'b1, 1'b0, 16'h2800, 8'h00);
        send_cfg(make_cfg(1'b0, 1'b1, 5'd15, cart_pkg::MAPPER_NROM));
        send_req(1'b1, 1'b0, 16'h2400, 8'h00);
        send_req(1'b1, 1'b0, 16'h2800, 8'h00);
        drain();
        end_test();
    endtask

    task automatic uxrom_test();
        start_test("uxrom");
        send_cfg(make_cfg(1'b0, 1'b0, 5'd17, cart_pkg::MAPPER_UXROM));
        send_req(1'b0, 1'b1, 16'h8000, 8'h03);
        send_req(1'b0, 1'b0, 16'h8010, 8'h00);
        send_req(1'b0, 1'b0, 16'hc020, 8'h00);
        send_req(1'b0, 1'b1, 16'hfff0, 8'h05);
        send_req(1'b0, 1'b0, 16'ha000, 8'h00);
        send_req(1'b0, 1'b0, 16'hffff, 8'h00);
        send_req(1'b1, 1'b0, 16'h0123, 8'h00);
        drain();
        end_test();
    endtask

    task automatic cnrom_test();
        start_test("cnrom");
        send_cfg(make_cfg(1'b0, 1'b0, 5'd15, cart_pkg::MAPPER_CNROM));
        send_req(1'b0, 1'b1, 16'h8000, 8'h02);
        send_req(1'b1, 1'b0, 16'h0123, 8'h00);
        send_req(1'b1, 1'b1, 16'h0040, 8'h5a);  // chr rom drops the write
        send_cfg(make_cfg(1'b1, 1'b0, 5'd15, cart_pkg::MAPPER_CNROM));
        send_req(1'b1, 1'b1, 16'h0040, 8'h5a);
        send_req(1'b0, 1'b1, 16'h8001, 8'h01);
        send_req(1'b1, 1'b0, 16'h1fff, 8'h00);
        drain();
        end_test();
    endtask

    task automatic latency_test();
        start_test("latency");
        check_latency = 1'b1;
        for (int i = 0; i < N_LATENCY; i++) begin
            if (i % 2 == 0)
                send_req(1'b0, 1'b0, 16'h8000 | 16'($urandom), 8'($urandom));
            else
                send_req(1'b1, 1'b0, 16'($urandom) & 16'h3fff, 8'($urandom));
        end
        drain();
        check_latency = 1'b0;
        end_test();
    endtask

    task automatic random_test();
        cart_pkg::prg_bits_t prg_bits;
        start_test("random");
        rand_ready <= 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            if ($urandom % 16 == 0) begin
                prg_bits = ($urandom % 2 == 0) ? 5'd0 : 5'(15 + $urandom % 6);
                send_cfg(make_cfg(1'($urandom), 1'($urandom), prg_bits, 5'($urandom % 4)));
            end
            send_req(1'($urandom), 1'($urandom), 16'($urandom), 8'($urandom));
            repeat ($urandom % 3) @(posedge clk);
        end
        drain();
        end_test();
    endtask

    initial begin
        void'($urandom(71314));
        cpu_reset = 1'b1;
        cfg_valid = 1'b0;
        cfg_data = '0;
        req_valid = 1'b0;
        req_ppu = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        mem_ready = 1'b1;
        reset_test();
        nrom_test();
        uxrom_test();
        cnrom_test();
        latency_test();
        random_test();
        $display("%0d tests, %0d transfers checked, %0d errors", tests_run, n_checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // watchdog allows 20 cycles per request
    initial begin
        #(TOTAL_REQS * 20 * CLK_PERIOD);
        $display("timeout: test %s did not finish, %0d transfers still expected",
                 test_name, exp_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- cart_mapper.f
src/cart_pkg.sv
src/access_if.sv
src/access_decode.sv
src/bank_execute.sv
src/access_result.sv
src/cart_mapper_top.sv
verif/cart_mapper_tb.sv
